// ==== Makefile ====
# Verilator flow for the bus core testbench
TOP = bus_core_tb
LOG = sim.log

.PHONY: lint sim check clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

// ==== flist.f ====
+incdir+include
source/bus_core_pkg.sv
source/cpu_bus_if.sv
source/address_decode.sv
source/work_ram.sv
source/mode_control.sv
source/read_data_mux.sv
source/atari_bus_core.sv
verification/bus_core_tb.sv

// ==== include/bus_core_defines.svh ====
////////////////////////////////////////
// Bus widths, memory map and INPUTCTRL
// limits for the system-bus core.
// Include in every RTL file.
////////////////////////////////////////
`ifndef BUS_CORE_DEFINES_SVH
`define BUS_CORE_DEFINES_SVH

// Bus widths
`define BUS_DATA_W 8
`define BUS_ADDR_W 16
`define RAM_ADDR_W 11 // 2 KB per bank

////////////////////////////////////////
// Memory map
////////////////////////////////////////
`define TIA_BASE  16'h0000
`define TIA_LAST  16'h001F

`define RAM0_BASE 16'h1800
`define RAM0_LAST 16'h1FFF

`define RAM1_BASE 16'h2000
`define RAM1_LAST 16'h27FF

// INPUTCTRL writes before halt requests pass
`define CTRL_WRITE_LIMIT 2

`endif

// ==== source/address_decode.sv ====
////////////////////////////////////////
// CPU address decoder. Turns the raw
// address and strobes into one-hot chip
// selects and a qualified write strobe.
////////////////////////////////////////
`timescale 1ns/1ps
`include "bus_core_defines.svh"

module address_decode (
	input  logic                   clk_sys,
	input  logic [`BUS_ADDR_W-1:0] addr,
	input  logic [`BUS_DATA_W-1:0] wdata,
	input  logic                   rw_n,
	input  logic                   bus_phase,
	cpu_bus_if.decoder             bus
);

	logic hit_tia;
	logic hit_ram0;
	logic hit_ram1;

	function automatic logic in_window(
		input logic [`BUS_ADDR_W-1:0] a,
		input logic [`BUS_ADDR_W-1:0] base,
		input logic [`BUS_ADDR_W-1:0] last
	);
		return (a >= base) && (a <= last);
	endfunction

	////////////////////////////////////////
	// Window compare
	////////////////////////////////////////
	assign hit_tia  = in_window(addr, `TIA_BASE, `TIA_LAST);
	assign hit_ram0 = in_window(addr, `RAM0_BASE, `RAM0_LAST);
	assign hit_ram1 = in_window(addr, `RAM1_BASE, `RAM1_LAST);

	assign bus.cs_tia  = hit_tia;
	assign bus.cs_ram0 = hit_ram0;
	assign bus.cs_ram1 = hit_ram1;
	assign bus.cs_cart = ~|{hit_tia, hit_ram0, hit_ram1}; // Cart takes the rest

	// Bus cycle passthrough and write qualify
	assign bus.addr      = addr;
	assign bus.wdata     = wdata;
	assign bus.rd        = rw_n;
	assign bus.wr_strobe = ~rw_n & bus_phase; // Only in phase 0

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////
	// Windows must never overlap and cart must fill every gap
	a_cs_onehot: assert property (
		@(posedge clk_sys) !$isunknown(addr) |->
			$onehot({bus.cs_tia, bus.cs_ram0, bus.cs_ram1, bus.cs_cart})
	) else $error("chip selects not one-hot at addr %h", addr);

endmodule

// ==== source/atari_bus_core.sv ====
////////////////////////////////////////
// System-bus core of a 7800-class
// console. CPU cycle in on plain ports,
// read data and mode outputs back out.
////////////////////////////////////////
`timescale 1ns/1ps
`include "bus_core_defines.svh"

module atari_bus_core (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [`BUS_ADDR_W-1:0] addr,
	input  logic [`BUS_DATA_W-1:0] wdata,
	input  logic                   rw_n,
	input  logic                   bus_phase, // Phase-0 strobe
	input  logic                   loading,
	input  logic [`BUS_DATA_W-1:0] clearval,
	input  logic                   bypass_bios,
	input  logic                   tia_mode,
	input  logic                   maria_halt_n,
	input  logic [`BUS_DATA_W-1:0] tia_data,
	input  logic [`BUS_DATA_W-1:0] bios_data,
	input  logic [`BUS_DATA_W-1:0] cart_data,
	output logic [`BUS_DATA_W-1:0] rdata,
	output logic                   cart_select,
	output logic                   maria_en,
	output logic                   bios_off,
	output logic                   tia_en,
	output logic                   ctrl_lock,
	output logic                   cpu_halt_n
);

	cpu_bus_if bus_if ();

	logic [`BUS_DATA_W-1:0] ram0_q;
	logic [`BUS_DATA_W-1:0] ram1_q;

	assign cart_select = bus_if.cs_cart;

	address_decode u_decode (
		.clk_sys   (clk_sys),
		.addr      (addr),
		.wdata     (wdata),
		.rw_n      (rw_n),
		.bus_phase (bus_phase),
		.bus       (bus_if.decoder)
	);

	work_ram u_ram (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.loading  (loading),
		.clearval (clearval),
		.bus      (bus_if.target),
		.ram0_q   (ram0_q),
		.ram1_q   (ram1_q)
	);

	mode_control u_mode (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus_if.target),
		.bypass_bios  (bypass_bios),
		.tia_mode     (tia_mode),
		.maria_halt_n (maria_halt_n),
		.maria_en     (maria_en),
		.bios_off     (bios_off),
		.tia_en       (tia_en),
		.ctrl_lock    (ctrl_lock),
		.cpu_halt_n   (cpu_halt_n)
	);

	read_data_mux u_mux (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus       (bus_if.target),
		.ram0_q    (ram0_q),
		.ram1_q    (ram1_q),
		.bios_off  (bios_off),
		.tia_data  (tia_data),
		.bios_data (bios_data),
		.cart_data (cart_data),
		.rdata     (rdata)
	);

endmodule

// ==== source/bus_core_pkg.sv ====
////////////////////////////////////////
// Shared types of the system-bus core.
// Refer to them as bus_core_pkg::name.
////////////////////////////////////////
`include "bus_core_defines.svh"

package bus_core_pkg;

	// INPUTCTRL byte, seen as a raw bus byte or as mode fields
	typedef union packed {
		logic [`BUS_DATA_W-1:0] raw;
		struct packed {
			logic [3:0] reserved;
			logic       tia_en;   // Bit 3
			logic       bios_off; // Bit 2
			logic       maria_en; // Bit 1
			logic       lock;     // Bit 0
		} fields;
	} inputctrl_u;

endpackage

// ==== source/cpu_bus_if.sv ====
////////////////////////////////////////
// Decoded CPU bus cycle. The decoder
// drives it and every bus target reads
// the same signals in the same cycle.
////////////////////////////////////////
`timescale 1ns/1ps
`include "bus_core_defines.svh"

interface cpu_bus_if;

	logic [`BUS_ADDR_W-1:0] addr;
	logic [`BUS_DATA_W-1:0] wdata;
	logic                   rd;        // High on read cycles
	logic                   wr_strobe; // Qualified write
	logic                   cs_ram0;
	logic                   cs_ram1;
	logic                   cs_tia;
	logic                   cs_cart;   // Anything unmapped

	modport decoder (
		output addr,
		output wdata,
		output rd,
		output wr_strobe,
		output cs_ram0,
		output cs_ram1,
		output cs_tia,
		output cs_cart
	);

	modport target (
		input addr,
		input wdata,
		input rd,
		input wr_strobe,
		input cs_ram0,
		input cs_ram1,
		input cs_tia,
		input cs_cart
	);

endinterface

// ==== source/mode_control.sv ====
////////////////////////////////////////
// INPUTCTRL mode register. Written through
// the TIA window until it locks itself;
// the CPU halt request passes only after
// enough writes.
////////////////////////////////////////
`timescale 1ns/1ps
`include "bus_core_defines.svh"

module mode_control (
	input  logic      clk_sys,
	input  logic      reset,
	cpu_bus_if.target bus,
	input  logic      bypass_bios,
	input  logic      tia_mode,
	input  logic      maria_halt_n,
	output logic      maria_en,
	output logic      bios_off,
	output logic      tia_en,
	output logic      ctrl_lock,
	output logic      cpu_halt_n
);

	localparam int CNT_W = $clog2(`CTRL_WRITE_LIMIT + 1);
	localparam logic [CNT_W-1:0] WRITE_LIMIT = CNT_W'(`CTRL_WRITE_LIMIT);

	bus_core_pkg::inputctrl_u ctrl_byte;
	logic [CNT_W-1:0]         write_count;
	logic                     setup_done; // Bypass preset or a real write seen
	logic                     ctrl_write;

	assign ctrl_byte.raw = bus.wdata;
	assign ctrl_write    = bus.wr_strobe & bus.cs_tia & ~ctrl_lock;

	////////////////////////////////////////
	// Register
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ctrl_lock   <= 1'b0;
			maria_en    <= 1'b0;
			bios_off    <= 1'b0;
			tia_en      <= 1'b0;
			write_count <= '0;
			setup_done  <= 1'b0;
		end else if (bypass_bios && !setup_done) begin
			// Skip the BIOS, land directly in the chosen mode
			ctrl_lock   <= tia_mode;
			maria_en    <= ~tia_mode;
			tia_en      <= tia_mode;
			bios_off    <= 1'b1;
			write_count <= WRITE_LIMIT;
			setup_done  <= 1'b1;
		end else if (ctrl_write) begin
			ctrl_lock  <= ctrl_byte.fields.lock;
			maria_en   <= ctrl_byte.fields.maria_en;
			bios_off   <= ctrl_byte.fields.bios_off;
			tia_en     <= ctrl_byte.fields.tia_en;
			setup_done <= 1'b1;
			if (write_count < WRITE_LIMIT) begin
				write_count <= write_count + 1'b1; // Saturates
			end
		end
	end

	// Halt ignored until the BIOS has configured the console
	assign cpu_halt_n = (write_count == WRITE_LIMIT) ? maria_halt_n : 1'b1;

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////
	a_count_limit: assert property (
		@(posedge clk_sys) disable iff (reset)
		write_count <= WRITE_LIMIT
	) else $error("INPUTCTRL write count %0d above limit", write_count);

endmodule

// ==== source/read_data_mux.sv ====
////////////////////////////////////////
// Read data selection and open-bus
// tracking. Unmapped bits of a read
// return the last value on the bus.
////////////////////////////////////////
`timescale 1ns/1ps
`include "bus_core_defines.svh"

module read_data_mux (
	input  logic                   clk_sys,
	input  logic                   reset,
	cpu_bus_if.target              bus,
	input  logic [`BUS_DATA_W-1:0] ram0_q,
	input  logic [`BUS_DATA_W-1:0] ram1_q,
	input  logic                   bios_off,
	input  logic [`BUS_DATA_W-1:0] tia_data,
	input  logic [`BUS_DATA_W-1:0] bios_data,
	input  logic [`BUS_DATA_W-1:0] cart_data,
	output logic [`BUS_DATA_W-1:0] rdata
);

	localparam int TIA_IN_W = 2; // Input bits driven by the TIA

	logic [`BUS_DATA_W-1:0] open_bus;
	logic                   bios_hit;

	// BIOS shadows the top half of cart space until switched off
	assign bios_hit = ~bios_off & bus.addr[`BUS_ADDR_W-1];

	////////////////////////////////////////
	// Open bus
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			open_bus <= '0;
		end else begin
			open_bus <= bus.rd ? rdata : bus.wdata;
		end
	end

	////////////////////////////////////////
	// Select
	////////////////////////////////////////
	always_comb begin
		rdata = open_bus;
		if (bus.cs_ram0) begin
			rdata = ram0_q;
		end else if (bus.cs_ram1) begin
			rdata = ram1_q;
		end else if (bus.cs_tia) begin
			rdata = {tia_data[`BUS_DATA_W-1 -: TIA_IN_W],
				open_bus[`BUS_DATA_W-TIA_IN_W-1:0]};
		end else if (bus.cs_cart) begin
			rdata = bios_hit ? bios_data : cart_data;
		end
	end

endmodule

// ==== source/work_ram.sv ====
////////////////////////////////////////
// Two 2 KB work-RAM banks with a bulk
// clear. While loading is high both banks
// take clearval, one address per cycle.
////////////////////////////////////////
`timescale 1ns/1ps
`include "bus_core_defines.svh"

module work_ram (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   loading,
	input  logic [`BUS_DATA_W-1:0] clearval,
	cpu_bus_if.target              bus,
	output logic [`BUS_DATA_W-1:0] ram0_q,
	output logic [`BUS_DATA_W-1:0] ram1_q
);

	localparam int RAM_DEPTH = 1 << `RAM_ADDR_W;
	localparam int NUM_BANKS = 2;

	logic [`RAM_ADDR_W-1:0] clear_addr;
	logic [`RAM_ADDR_W-1:0] ram_addr;
	logic [`BUS_DATA_W-1:0] ram_din;
	logic [NUM_BANKS-1:0]   bank_we;

	////////////////////////////////////////
	// Clear sequencer
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clear_addr <= '0;
		end else if (loading) begin
			clear_addr <= clear_addr + 1'b1; // Wraps after 2048
		end
	end

	// Clear owns both banks while loading
	assign ram_addr = loading ? clear_addr : bus.addr[`RAM_ADDR_W-1:0];
	assign ram_din  = loading ? clearval : bus.wdata;
	assign bank_we  = loading ? {NUM_BANKS{1'b1}} :
		({bus.cs_ram1, bus.cs_ram0} & {NUM_BANKS{bus.wr_strobe}});

	////////////////////////////////////////
	// Banks
	////////////////////////////////////////
	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		logic [`BUS_DATA_W-1:0] mem [RAM_DEPTH];
		logic [`BUS_DATA_W-1:0] q;

		always_ff @(posedge clk_sys) begin
			if (bank_we[b]) begin
				mem[ram_addr] <= ram_din;
			end
			q <= mem[ram_addr]; // Old data on a same-cycle write
		end
	end

	assign ram0_q = g_bank[0].q;
	assign ram1_q = g_bank[1].q;

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////
	// The CPU is held off the bus for the whole cartridge load
	a_no_write_in_load: assert property (
		@(posedge clk_sys) disable iff (reset)
		loading |-> !bus.wr_strobe
	) else $error("bus write during RAM clear at addr %h", bus.addr);

endmodule

// ==== verification/bus_core_tb.sv ====
////////////////////////////////////////
// Table-driven testbench for the bus
// core. Each row drives one bus cycle on
// the falling edge and checks rdata and
// the mode outputs one edge later.
////////////////////////////////////////
`timescale 1ns/1ps
`include "bus_core_defines.svh"

module bus_core_tb;

	localparam int RESET_CYCLES = 10;
	localparam int CLEAR_CYCLES = 1 << `RAM_ADDR_W;
	localparam logic [7:0] BIOS_BYTE = 8'hB5;
	localparam logic [7:0] CART_BYTE = 8'h5A;

	typedef enum {OP_READ, OP_TIA_READ, OP_WRITE, OP_IDLE, OP_RESET} op_e;

	typedef struct {
		string       name;
		op_e         op;
		logic [15:0] addr;
		logic [7:0]  data;      // wdata, also tia_data
		logic [3:0]  ctl;       // bus_phase, bypass_bios, tia_mode, maria_halt_n
		logic [7:0]  exp_rdata;
		logic [5:0]  exp_flags; // cart_select, tia_en, bios_off, maria_en, lock, cpu_halt_n
	} test_t;

	logic                   clk_sys = 1'b0;
	logic                   reset;
	logic [`BUS_ADDR_W-1:0] addr;
	logic [`BUS_DATA_W-1:0] wdata;
	logic                   rw_n;
	logic                   bus_phase;
	logic                   loading;
	logic [`BUS_DATA_W-1:0] clearval;
	logic                   bypass_bios;
	logic                   tia_mode;
	logic                   maria_halt_n;
	logic [`BUS_DATA_W-1:0] tia_data;
	logic [`BUS_DATA_W-1:0] bios_data;
	logic [`BUS_DATA_W-1:0] cart_data;
	logic [`BUS_DATA_W-1:0] rdata;
	logic                   cart_select;
	logic                   maria_en;
	logic                   bios_off;
	logic                   tia_en;
	logic                   ctrl_lock;
	logic                   cpu_halt_n;

	test_t      tests[$];
	logic [7:0] open_bus_model; // Last byte seen on the bus
	logic       test_ok;
	int         errors = 0;
	int         tests_failed = 0;
	int         cycles = 0;
	int         timeout_limit;
	int         seed = 32'h5eb8;

	atari_bus_core DUT (.*);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > timeout_limit) begin
			$display("Timeout: run went past %0d cycles", timeout_limit);
			$display("Test failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// Checks and stimulus
	////////////////////////////////////////
	task automatic check_value(input string name, input string what,
		input logic [7:0] want, input logic [7:0] got);
		assert (got === want) else begin
			$display("Error %s: %s expected %h, actual %h", name, what, want, got);
			test_ok = 1'b0;
			errors++;
		end
	endtask

	task automatic add_test(input string name, input op_e op, input logic [15:0] a,
		input logic [7:0] d, input logic [3:0] ctl, input logic [7:0] exp_rdata,
		input logic [5:0] exp_flags);
		test_t t = '{name, op, a, d, ctl, exp_rdata, exp_flags};
		tests.push_back(t);
	endtask

	task automatic apply_test(input test_t t);
		logic [7:0] got;
		logic [7:0] want;
		bypass_bios = t.ctl[2];
		tia_mode    = t.ctl[1];
		if (t.op == OP_RESET) begin
			reset = 1'b1;
			repeat (RESET_CYCLES) @(negedge clk_sys);
			reset = 1'b0;
		end
		addr         = t.addr;
		wdata        = t.data;
		tia_data     = t.data;
		rw_n         = (t.op != OP_WRITE);
		bus_phase    = t.ctl[3];
		maria_halt_n = t.ctl[0];
		test_ok      = 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		got  = rdata;
		// TIA drives only the top two bits
		want = (t.op == OP_TIA_READ) ? {t.data[7:6], open_bus_model[5:0]} : t.exp_rdata;
		if (t.op == OP_READ || t.op == OP_TIA_READ) begin
			check_value(t.name, "rdata", want, got);
		end
		check_value(t.name, "cart_select", {7'd0, t.exp_flags[5]}, {7'd0, cart_select});
		check_value(t.name, "mode", {4'd0, t.exp_flags[4:1]},
			{4'd0, tia_en, bios_off, maria_en, ctrl_lock});
		check_value(t.name, "cpu_halt_n", {7'd0, t.exp_flags[0]}, {7'd0, cpu_halt_n});
		bus_phase = 1'b0; // Second cycle lets the open bus settle
		@(posedge clk_sys);
		@(negedge clk_sys);
		open_bus_model = (t.op == OP_WRITE) ? t.data : got;
		if (!test_ok) begin
			tests_failed++;
		end
		$display("%s %s", test_ok ? "[ok] " : "[bad]", t.name);
	endtask

	////////////////////////////////////////
	// Test table
	////////////////////////////////////////
	// ctl is {bus_phase, bypass, tia_mode, halt_n}
	// flags are {cart_select, tia_en, bios_off, maria_en, lock, cpu_halt_n}
	task automatic build_tests(input logic [7:0] cv);
		add_test("reset_halt_low", OP_IDLE, 16'h0400, 8'h00, 4'b0000, 8'h00, 6'b1_0000_1);
		add_test("reset_halt_high", OP_IDLE, 16'h0400, 8'h00, 4'b0001, 8'h00, 6'b1_0000_1);
		add_test("clear_bank0_first", OP_READ, 16'h1800, 8'h00, 4'b0001, cv, 6'b0_0000_1);
		add_test("clear_bank0_mid", OP_READ, 16'h1C00, 8'h00, 4'b0001, cv, 6'b0_0000_1);
		add_test("clear_bank0_last", OP_READ, 16'h1FFF, 8'h00, 4'b0001, cv, 6'b0_0000_1);
		add_test("clear_bank1_first", OP_READ, 16'h2000, 8'h00, 4'b0001, cv, 6'b0_0000_1);
		add_test("clear_bank1_mid", OP_READ, 16'h2400, 8'h00, 4'b0001, cv, 6'b0_0000_1);
		add_test("clear_bank1_last", OP_READ, 16'h27FF, 8'h00, 4'b0001, cv, 6'b0_0000_1);
		add_test("bank0_write", OP_WRITE, 16'h1810, 8'hA1, 4'b1001, 8'h00, 6'b0_0000_1);
		add_test("bank1_write", OP_WRITE, 16'h2010, 8'hB2, 4'b1001, 8'h00, 6'b0_0000_1);
		add_test("bank0_readback", OP_READ, 16'h1810, 8'h00, 4'b0001, 8'hA1, 6'b0_0000_1);
		add_test("bank1_readback", OP_READ, 16'h2010, 8'h00, 4'b0001, 8'hB2, 6'b0_0000_1);
		add_test("bank0_write_2", OP_WRITE, 16'h1820, 8'hC3, 4'b1001, 8'h00, 6'b0_0000_1);
		add_test("bank1_mirror_kept", OP_READ, 16'h2020, 8'h00, 4'b0001, cv, 6'b0_0000_1);
		add_test("write_no_phase", OP_WRITE, 16'h2030, ~cv, 4'b0001, 8'h00, 6'b0_0000_1);
		add_test("no_phase_kept", OP_READ, 16'h2030, 8'h00, 4'b0001, cv, 6'b0_0000_1);
		add_test("bank0_readback_2", OP_READ, 16'h1820, 8'h00, 4'b0001, 8'hC3, 6'b0_0000_1);
		add_test("bios_read", OP_READ, 16'h8000, 8'h00, 4'b0001, BIOS_BYTE, 6'b1_0000_1);
		add_test("cart_read", OP_READ, 16'h4000, 8'h00, 4'b0001, CART_BYTE, 6'b1_0000_1);
		add_test("open_bus_write", OP_WRITE, 16'h1840, 8'h2B, 4'b1001, 8'h00, 6'b0_0000_1);
		add_test("tia_read", OP_TIA_READ, 16'h0008, 8'hC0, 4'b0001, 8'h00, 6'b0_0000_1);
		add_test("tia_read_2", OP_TIA_READ, 16'h0009, 8'h40, 4'b0001, 8'h00, 6'b0_0000_1);
		// INPUTCTRL through the TIA window
		add_test("ctrl_write_1", OP_WRITE, 16'h0001, 8'h06, 4'b1000, 8'h00, 6'b0_0110_1);
		add_test("halt_still_held", OP_IDLE, 16'h0400, 8'h00, 4'b0000, 8'h00, 6'b1_0110_1);
		add_test("ctrl_write_2", OP_WRITE, 16'h0001, 8'h06, 4'b1000, 8'h00, 6'b0_0110_0);
		add_test("halt_follow_high", OP_IDLE, 16'h0400, 8'h00, 4'b0001, 8'h00, 6'b1_0110_1);
		add_test("halt_follow_low", OP_IDLE, 16'h0400, 8'h00, 4'b0000, 8'h00, 6'b1_0110_0);
		add_test("bios_off_hi", OP_READ, 16'h8000, 8'h00, 4'b0001, CART_BYTE, 6'b1_0110_1);
		add_test("bios_off_lo", OP_READ, 16'h4000, 8'h00, 4'b0001, CART_BYTE, 6'b1_0110_1);
		add_test("ctrl_write_lock", OP_WRITE, 16'h0001, 8'h0D, 4'b1001, 8'h00, 6'b0_1101_1);
		add_test("ctrl_write_locked", OP_WRITE, 16'h0001, 8'h02, 4'b1001, 8'h00, 6'b0_1101_1);
		// Bypass resets
		add_test("bypass_tia", OP_RESET, 16'h0400, 8'h00, 4'b0110, 8'h00, 6'b1_1101_0);
		add_test("bypass_tia_high", OP_IDLE, 16'h0400, 8'h00, 4'b0111, 8'h00, 6'b1_1101_1);
		add_test("bypass_maria", OP_RESET, 16'h0400, 8'h00, 4'b0100, 8'h00, 6'b1_0110_0);
		add_test("bypass_maria_high", OP_IDLE, 16'h0400, 8'h00, 4'b0101, 8'h00, 6'b1_0110_1);
		add_test("plain_reset", OP_RESET, 16'h0400, 8'h00, 4'b0000, 8'h00, 6'b1_0000_1);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		logic [31:0] rnd;
		logic [7:0]  cv;
		int          resets;
		reset          = 1'b1;
		addr           = '0;
		wdata          = '0;
		rw_n           = 1'b1;
		bus_phase      = 1'b0;
		loading        = 1'b0;
		clearval       = '0;
		bypass_bios    = 1'b0;
		tia_mode       = 1'b0;
		maria_halt_n   = 1'b1;
		tia_data       = '0;
		bios_data      = BIOS_BYTE;
		cart_data      = CART_BYTE;
		open_bus_model = '0;
		rnd = $random(seed);
		cv  = rnd[7:0];
		build_tests(cv);
		resets = 1;
		foreach (tests[i]) begin
			if (tests[i].op == OP_RESET) begin
				resets++;
			end
		end
		timeout_limit = RESET_CYCLES * resets + CLEAR_CYCLES + 3 * tests.size() + 100;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		reset = 1'b0;
		clearval = cv; // Bulk clear, one address per cycle
		loading  = 1'b1;
		repeat (CLEAR_CYCLES) @(negedge clk_sys);
		loading = 1'b0;
		foreach (tests[i]) begin
			apply_test(tests[i]);
		end
		$display("%0d tests, %0d failed, %0d check errors", tests.size(), tests_failed, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
